//--- tileLineRenderer.f
+incdir+.
renderPixelPkg.sv
renderCtlPkg.sv
pixelMerge.sv
tileRowStore.sv
spanSequencer.sv
lineBuffer.sv
tileLineRenderer.sv
tileLineRenderer_tb.sv

//--- Bender.yml
package:
  name: tileLineRenderer

export_include_dirs:
  - .

sources:
  - renderPixelPkg.sv
  - renderCtlPkg.sv
  - pixelMerge.sv
  - tileRowStore.sv
  - spanSequencer.sv
  - lineBuffer.sv
  - tileLineRenderer.sv
  - target: test
    files:
      - tileLineRenderer_tb.sv

//--- tileLineRenderer_tb.sv
`include "tileLineRenderer_config.svh"

module tileLineRenderer_tb
	import renderPixelPkg::*;
;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MaxEntries = 16;
	localparam int CountW = $clog2(`TILE_COUNT) + 1;
	localparam int SetupCycles = 10 + `TILE_COUNT * `TILE_ROWS + 16;

	logic clk;
	logic rst;
	logic tileWrEn;
	tileIdT tileWrId;
	tileRowIdT tileWrRow;
	tileRowT tileWrData;
	logic cmdValid;
	logic cmdReady;
	wordAddrT cmdWord;
	offsetT cmdOffset;
	logic cmdFlip;
	layerDepthT cmdDepth;
	paletteT cmdPalette;
	tileIdT cmdTileBase;
	logic [CountW-1:0] cmdTileCount;
	tileRowIdT cmdRow;
	logic scanValid;
	logic scanReady;
	logic pixOutValid;
	logic pixOutReady;
	pixelWordT pixOutData;
	slotMaskT pixOutMask;

	logic [31:0] lfsrState = 32'h4cf3_e12c;
	int watchLimit = 0;

	// Span table with one column per command field
	int numEntries = 0;
	string spanName [MaxEntries];
	int spanWord [MaxEntries];
	int spanOffset [MaxEntries];
	int spanFlip [MaxEntries];
	int spanDepth [MaxEntries];
	int spanPalette [MaxEntries];
	int spanBase [MaxEntries];
	int spanCount [MaxEntries];
	int spanRow [MaxEntries];
	int spanScan [MaxEntries];

	// Tile rows as loaded, and the expected line per slot
	tileRowT tileMem [`TILE_COUNT * `TILE_ROWS];
	logic [7:0] linePix [`LINE_WORDS * 4];
	logic lineFlag [`LINE_WORDS * 4];
	layerDepthT lineDepth [`LINE_WORDS * 4];

	tileLineRenderer u_dut (
		.clk(clk), .rst(rst), .tileWrEn(tileWrEn), .tileWrId(tileWrId),
		.tileWrRow(tileWrRow), .tileWrData(tileWrData), .cmdValid(cmdValid),
		.cmdReady(cmdReady), .cmdWord(cmdWord), .cmdOffset(cmdOffset), .cmdFlip(cmdFlip),
		.cmdDepth(cmdDepth), .cmdPalette(cmdPalette), .cmdTileBase(cmdTileBase),
		.cmdTileCount(cmdTileCount), .cmdRow(cmdRow), .scanValid(scanValid),
		.scanReady(scanReady), .pixOutValid(pixOutValid), .pixOutReady(pixOutReady),
		.pixOutData(pixOutData), .pixOutMask(pixOutMask)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsrBit()};
		end
		return v;
	endfunction

	task automatic stopOnFailure();
		$display("tests failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic checkWord(input string name, input pixelWordT expected, input pixelWordT actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkMask(input string name, input slotMaskT expected, input slotMaskT actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %b, actual %b", name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %b, actual %b", name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic addEntry(input string name, input int word, input int offset, input int flip,
		input int depth, input int palette, input int base, input int count, input int row,
		input int scan);
		spanName[numEntries] = name;
		spanWord[numEntries] = word;
		spanOffset[numEntries] = offset;
		spanFlip[numEntries] = flip;
		spanDepth[numEntries] = depth;
		spanPalette[numEntries] = palette;
		spanBase[numEntries] = base;
		spanCount[numEntries] = count;
		spanRow[numEntries] = row;
		spanScan[numEntries] = scan;
		numEntries++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Line model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [3:0] tilePixel(input int tile, input int row, input int col,
		input int flip);
		int c;
		c = (flip != 0) ? 7 - col : col;
		return tileMem[tile * `TILE_ROWS + row][4*c +: 4];
	endfunction

	// Word j slot s shows span pixel 4j+s-offset or zero outside the run
	task automatic modelSpan(input int e);
		int numWords;
		int addr;
		int g;
		int slot;
		int tile;
		logic [3:0] colour;
		numWords = 2 * spanCount[e] + ((spanOffset[e] != 0) ? 1 : 0);
		for (int j = 0; j < numWords; j++) begin
			addr = (spanWord[e] + j) % `LINE_WORDS;
			for (int s = 0; s < 4; s++) begin
				g = 4 * j + s - spanOffset[e];
				colour = 4'h0;
				if (g >= 0 && g < 8 * spanCount[e]) begin
					tile = (spanBase[e] + g / 8) % `TILE_COUNT;
					colour = tilePixel(tile, spanRow[e], g % 8, spanFlip[e]);
				end
				slot = addr * 4 + s;
				if (colour != 4'h0 && (!lineFlag[slot] || spanDepth[e] > lineDepth[slot])) begin
					linePix[slot] = {spanPalette[e][3:0], colour};
					lineFlag[slot] = 1'b1;
					lineDepth[slot] = layerDepthT'(spanDepth[e]);
				end
			end
		end
	endtask

	function automatic pixelWordT expectedWord(input int addr);
		pixelWordT w;
		for (int s = 0; s < 4; s++) begin
			w[8*s +: 8] = linePix[addr*4 + s];
		end
		return w;
	endfunction

	function automatic slotMaskT expectedMask(input int addr);
		slotMaskT m;
		for (int s = 0; s < 4; s++) begin
			m[s] = lineFlag[addr*4 + s];
		end
		return m;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Bus tasks
	//////////////////////////////////////////////////////////////////////

	// Some nibbles forced to colour 0 for transparency
	task automatic loadTiles();
		tileRowT rowData;
		logic [3:0] nib;
		for (int a = 0; a < `TILE_COUNT * `TILE_ROWS; a++) begin
			for (int i = 0; i < 8; i++) begin
				nib = 4'(takeBits(4));
				if (takeBits(2) == 0) begin
					nib = 4'h0;
				end
				rowData[4*i +: 4] = nib;
			end
			tileMem[a] = rowData;
			@(posedge clk);
			tileWrEn <= 1'b1;
			tileWrId <= tileIdT'(a / `TILE_ROWS);
			tileWrRow <= tileRowIdT'(a % `TILE_ROWS);
			tileWrData <= rowData;
		end
		@(posedge clk);
		tileWrEn <= 1'b0;
	endtask

	task automatic sendSpan(input int e);
		@(posedge clk);
		cmdValid <= 1'b1;
		cmdWord <= wordAddrT'(spanWord[e]);
		cmdOffset <= offsetT'(spanOffset[e]);
		cmdFlip <= spanFlip[e][0];
		cmdDepth <= layerDepthT'(spanDepth[e]);
		cmdPalette <= paletteT'(spanPalette[e]);
		cmdTileBase <= tileIdT'(spanBase[e]);
		cmdTileCount <= CountW'(spanCount[e]);
		cmdRow <= tileRowIdT'(spanRow[e]);
		do begin
			@(negedge clk);
		end while (!cmdReady);
		@(posedge clk);
		cmdValid <= 1'b0;
		modelSpan(e);
	endtask

	// Data must match the pending word on every valid cycle whether or not ready is high
	task automatic scanLine(input string name);
		int got;
		got = 0;
		@(posedge clk);
		scanValid <= 1'b1;
		do begin
			@(negedge clk);
		end while (!scanReady);
		while (got < `LINE_WORDS) begin
			@(posedge clk);
			scanValid <= 1'b0;
			pixOutReady <= lfsrBit();
			@(negedge clk);
			if (pixOutValid) begin
				checkWord($sformatf("%s word %0d", name, got), expectedWord(got), pixOutData);
				checkMask($sformatf("%s mask %0d", name, got), expectedMask(got), pixOutMask);
				if (pixOutReady) begin
					got++;
				end
			end
		end
		@(posedge clk);
		pixOutReady <= 1'b0;
		@(negedge clk);
		checkFlag($sformatf("%s valid after last word", name), 1'b0, pixOutValid);
		for (int i = 0; i < `LINE_WORDS * 4; i++) begin
			lineFlag[i] = 1'b0;
			linePix[i] = 8'h00;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		wait (watchLimit > 0);
		repeat (watchLimit) @(posedge clk);
		$display("Watchdog: the run did not finish within %0d clock cycles", watchLimit);
		$display("tests failed");
		$fatal(1, "simulation hung");
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int scans;
		int spanCycles;
		rst = 1'b1;
		tileWrEn = 1'b0;
		tileWrId = '0;
		tileWrRow = '0;
		tileWrData = '0;
		cmdValid = 1'b0;
		cmdWord = '0;
		cmdOffset = '0;
		cmdFlip = 1'b0;
		cmdDepth = '0;
		cmdPalette = '0;
		cmdTileBase = '0;
		cmdTileCount = '0;
		cmdRow = '0;
		scanValid = 1'b0;
		pixOutReady = 1'b0;
		for (int i = 0; i < `LINE_WORDS * 4; i++) begin
			linePix[i] = 8'h00;
			lineFlag[i] = 1'b0;
			lineDepth[i] = '0;
		end

		// name, word, offset, flip, depth, palette, base, count, row, scan
		addEntry("offset0Plain", 0, 0, 0, 1, 3, 0, 4, 0, 1);
		addEntry("offset1Carry", 10, 1, 0, 1, 5, 4, 3, 2, 0);
		addEntry("offset2Carry", 20, 2, 0, 1, 8, 9, 3, 5, 0);
		addEntry("offset3Carry", 30, 3, 0, 2, 10, 17, 4, 7, 1);
		addEntry("flipSpan", 5, 0, 1, 2, 9, 30, 5, 3, 0);
		addEntry("flipOffset", 40, 2, 1, 0, 12, 40, 6, 6, 1);
		addEntry("layerLow", 0, 0, 0, 1, 1, 8, 8, 1, 0);
		addEntry("layerHigh", 4, 1, 0, 3, 2, 20, 6, 4, 0);
		addEntry("layerEqual", 2, 0, 0, 1, 7, 33, 6, 0, 0);
		addEntry("layerUnder", 6, 3, 0, 0, 14, 50, 4, 2, 1);
		addEntry("wrapAround", 60, 1, 0, 2, 6, 62, 4, 5, 0);
		addEntry("longSpan", 24, 0, 0, 2, 11, 0, 16, 7, 1);

		scans = 2;
		spanCycles = 0;
		for (int e = 0; e < numEntries; e++) begin
			spanCycles += 3 * spanCount[e] + 2;
			scans += spanScan[e];
		end
		watchLimit = SetupCycles + 4 * spanCycles + scans * 8 * `LINE_WORDS;

		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		checkFlag("reset cmdReady", 1'b1, cmdReady);
		checkFlag("reset scanReady", 1'b1, scanReady);
		checkFlag("reset pixOutValid", 1'b0, pixOutValid);

		loadTiles();
		scanLine("emptyLine");

		for (int e = 0; e < numEntries; e++) begin
			sendSpan(e);
			if (spanScan[e] != 0) begin
				scanLine(spanName[e]);
			end
		end

		// Second scan straight after the last one expects an empty line
		scanLine("rescanEmpty");

		$display("all tests passed");
		$finish;
	end

endmodule

//--- tileLineRenderer.sv
`include "tileLineRenderer_config.svh"

module tileLineRenderer
	import renderPixelPkg::*;
(
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         tileWrEn,
	input  tileIdT                       tileWrId,
	input  tileRowIdT                    tileWrRow,
	input  tileRowT                      tileWrData,
	input  logic                         cmdValid,
	output logic                         cmdReady,
	input  wordAddrT                     cmdWord,
	input  offsetT                       cmdOffset,
	input  logic                         cmdFlip,
	input  layerDepthT                   cmdDepth,
	input  paletteT                      cmdPalette,
	input  tileIdT                       cmdTileBase,
	input  logic [$clog2(`TILE_COUNT):0] cmdTileCount,
	input  tileRowIdT                    cmdRow,
	input  logic                         scanValid,
	output logic                         scanReady,
	output logic                         pixOutValid,
	input  logic                         pixOutReady,
	output pixelWordT                    pixOutData,
	output slotMaskT                     pixOutMask
);

	tileIdT fetchId;
	tileRowIdT fetchRow;
	tileRowT fetchData;
	logic mergeEn, mergeFirst, mergeFlip, mergeBlank;
	wordAddrT mergeAddr;
	offsetT mergeOffset;
	layerDepthT mergeDepth;
	paletteT mergePalette;
	carryT mergeCarry, carryOut;
	pixelWordT curData, newData;
	slotMaskT curMask, newMask;
	depthWordT curDepth, newDepth;
	logic scanStart, scanBusy;

	tileRowStore uTileStore (
		.clk(clk), .wrEn(tileWrEn), .wrId(tileWrId), .wrRow(tileWrRow), .wrData(tileWrData),
		.rdId(fetchId), .rdRow(fetchRow), .rdData(fetchData)
	);

	spanSequencer uSequencer (
		.clk(clk), .rst(rst), .cmdValid(cmdValid), .cmdWord(cmdWord), .cmdOffset(cmdOffset),
		.cmdFlip(cmdFlip), .cmdDepth(cmdDepth), .cmdPalette(cmdPalette),
		.cmdTileBase(cmdTileBase), .cmdTileCount(cmdTileCount), .cmdRow(cmdRow),
		.scanValid(scanValid), .scanBusy(scanBusy), .carryOut(carryOut),
		.cmdReady(cmdReady), .scanReady(scanReady), .scanStart(scanStart),
		.fetchId(fetchId), .fetchRow(fetchRow), .mergeEn(mergeEn), .mergeAddr(mergeAddr),
		.mergeFirst(mergeFirst), .mergeOffset(mergeOffset), .mergeFlip(mergeFlip),
		.mergeDepth(mergeDepth), .mergePalette(mergePalette), .mergeCarry(mergeCarry),
		.mergeBlank(mergeBlank)
	);

	// Alignment and depth test for the word at mergeAddr
	pixelMerge uMerge (
		.tileRow(fetchData), .first(mergeFirst), .offset(mergeOffset), .flip(mergeFlip),
		.blank(mergeBlank), .palette(mergePalette), .depth(mergeDepth), .carryIn(mergeCarry),
		.curData(curData), .curMask(curMask), .curDepth(curDepth), .newData(newData),
		.newMask(newMask), .newDepth(newDepth), .carryOut(carryOut)
	);

	lineBuffer uLineBuffer (
		.clk(clk), .rst(rst), .mergeEn(mergeEn), .mergeAddr(mergeAddr), .newData(newData),
		.newMask(newMask), .newDepth(newDepth), .scanStart(scanStart),
		.pixOutReady(pixOutReady), .curData(curData), .curMask(curMask),
		.curDepth(curDepth), .pixOutValid(pixOutValid), .pixOutData(pixOutData),
		.pixOutMask(pixOutMask), .scanBusy(scanBusy)
	);

endmodule

//--- lineBuffer.sv
`include "tileLineRenderer_config.svh"

module lineBuffer
	import renderPixelPkg::*;
	import renderCtlPkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      mergeEn,
	input  wordAddrT  mergeAddr,
	input  pixelWordT newData,
	input  slotMaskT  newMask,
	input  depthWordT newDepth,
	input  logic      scanStart,
	input  logic      pixOutReady,
	output pixelWordT curData,
	output slotMaskT  curMask,
	output depthWordT curDepth,
	output logic      pixOutValid,
	output pixelWordT pixOutData,
	output slotMaskT  pixOutMask,
	output logic      scanBusy
);

	pixelWordT dataMem [`LINE_WORDS];
	slotMaskT maskMem [`LINE_WORDS];
	depthWordT depthMem [`LINE_WORDS];

	scanStateT scanState;
	wordAddrT scanAddr;
	logic scanTake;
	pixelWordT scanWord;
	slotMaskT scanMask;

	// Merge port reads the addressed word in the same cycle
	assign curData = dataMem[mergeAddr];
	assign curMask = maskMem[mergeAddr];
	assign curDepth = depthMem[mergeAddr];

	assign scanTake = pixOutValid && pixOutReady;

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (mergeEn) begin
			dataMem[mergeAddr] <= newData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `LINE_WORDS; i++) begin
				maskMem[i] <= '0;
			end
		end else begin
			if (mergeEn) begin
				maskMem[mergeAddr] <= newMask;
			end
			if (scanTake) begin
				maskMem[scanAddr] <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mergeEn) begin
			depthMem[mergeAddr] <= newDepth;
		end
		if (scanTake) begin
			depthMem[scanAddr] <= '0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Scan-out
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			scanState <= scanIdle;
			scanAddr <= '0;
		end else begin
			case (scanState)
				scanIdle: begin
					if (scanStart) begin
						scanState <= scanStream;
						scanAddr <= '0;
					end
				end
				scanStream: begin
					if (scanTake) begin
						if (scanAddr == wordAddrT'(`LINE_WORDS - 1)) begin
							scanState <= scanIdle;
						end
						scanAddr <= scanAddr + 1'b1;
					end
				end
				default: scanState <= scanIdle;
			endcase
		end
	end

	assign pixOutValid = (scanState == scanStream);
	assign scanBusy = (scanState == scanStream);
	assign scanWord = dataMem[scanAddr];
	assign scanMask = maskMem[scanAddr];
	assign pixOutMask = scanMask;

	// Unwritten slots read as zero
	always_comb begin
		for (int s = 0; s < 4; s++) begin
			pixOutData[8*s +: 8] = scanMask[s] ? scanWord[8*s +: 8] : 8'h00;
		end
	end

endmodule

//--- spanSequencer.sv
`include "tileLineRenderer_config.svh"

module spanSequencer
	import renderPixelPkg::*;
	import renderCtlPkg::*;
(
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           cmdValid,
	input  wordAddrT                       cmdWord,
	input  offsetT                         cmdOffset,
	input  logic                           cmdFlip,
	input  layerDepthT                     cmdDepth,
	input  paletteT                        cmdPalette,
	input  tileIdT                         cmdTileBase,
	input  logic [$clog2(`TILE_COUNT):0]   cmdTileCount,
	input  tileRowIdT                      cmdRow,
	input  logic                           scanValid,
	input  logic                           scanBusy,
	input  carryT                          carryOut,
	output logic                           cmdReady,
	output logic                           scanReady,
	output logic                           scanStart,
	output tileIdT                         fetchId,
	output tileRowIdT                      fetchRow,
	output logic                           mergeEn,
	output wordAddrT                       mergeAddr,
	output logic                           mergeFirst,
	output offsetT                         mergeOffset,
	output logic                           mergeFlip,
	output layerDepthT                     mergeDepth,
	output paletteT                        mergePalette,
	output carryT                          mergeCarry,
	output logic                           mergeBlank
);

	seqStateT state;
	wordAddrT wordPtr;
	offsetT offsetReg;
	logic flipReg;
	layerDepthT depthReg;
	paletteT paletteReg;
	tileIdT tileId;
	tileRowIdT rowReg;
	logic [$clog2(`TILE_COUNT):0] tilesLeft;
	carryT carryReg;
	logic spanAccept;
	logic spanStart;

	// Spans win over scans when both are offered
	assign cmdReady = (state == seqIdle);
	assign scanReady = (state == seqIdle) && !cmdValid;
	assign scanStart = scanReady && scanValid;
	assign spanAccept = cmdReady && cmdValid;
	assign spanStart = spanAccept && (cmdTileCount != '0);

	assign fetchId = tileId;
	assign fetchRow = rowReg;
	assign mergeEn = (state == seqLowHalf) || (state == seqHighHalf) || (state == seqFlush);
	assign mergeFirst = (state == seqHighHalf);
	assign mergeBlank = (state == seqFlush);
	assign mergeAddr = wordPtr;
	assign mergeOffset = offsetReg;
	assign mergeFlip = flipReg;
	assign mergeDepth = depthReg;
	assign mergePalette = paletteReg;
	assign mergeCarry = carryReg;

	//////////////////////////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= seqIdle;
			carryReg <= '0;
		end else begin
			case (state)
				seqIdle: begin
					if (spanStart) begin
						state <= seqFetch;
						carryReg <= '0;
					end else if (scanStart) begin
						state <= seqScan;
					end
				end
				seqFetch: state <= seqLowHalf;
				seqLowHalf: state <= seqHighHalf;
				seqHighHalf: begin
					carryReg <= carryOut;
					if (tilesLeft == 1) begin
						// A nonzero offset leaves pixels for one more word
						state <= (offsetReg != '0) ? seqFlush : seqIdle;
					end else begin
						state <= seqFetch;
					end
				end
				seqFlush: state <= seqIdle;
				seqScan: begin
					if (!scanBusy) begin
						state <= seqIdle;
					end
				end
				default: state <= seqIdle;
			endcase
		end
	end

	// Span fields and walk counters
	always_ff @(posedge clk) begin
		if (spanAccept) begin
			wordPtr <= cmdWord;
			offsetReg <= cmdOffset;
			flipReg <= cmdFlip;
			depthReg <= cmdDepth;
			paletteReg <= cmdPalette;
			tileId <= cmdTileBase;
			rowReg <= cmdRow;
			tilesLeft <= cmdTileCount;
		end
		if (mergeEn) begin
			wordPtr <= wordPtr + 1'b1;
		end
		if (state == seqHighHalf) begin
			tileId <= tileId + 1'b1;
			tilesLeft <= tilesLeft - 1'b1;
		end
	end

endmodule

//--- tileRowStore.sv
`include "tileLineRenderer_config.svh"

module tileRowStore
	import renderPixelPkg::*;
(
	input  logic      clk,
	input  logic      wrEn,
	input  tileIdT    wrId,
	input  tileRowIdT wrRow,
	input  tileRowT   wrData,
	input  tileIdT    rdId,
	input  tileRowIdT rdRow,
	output tileRowT   rdData
);

	localparam int RowDepth = `TILE_COUNT * `TILE_ROWS;
	localparam int RowAddrW = $clog2(RowDepth);

	tileRowT rowMem [RowDepth];
	logic [RowAddrW-1:0] wrAddr;
	logic [RowAddrW-1:0] rdAddr;

	// Tile id above row index
	assign wrAddr = {wrId, wrRow};
	assign rdAddr = {rdId, rdRow};

	always_ff @(posedge clk) begin
		if (wrEn) begin
			rowMem[wrAddr] <= wrData;
		end
	end

	// Registered read, data one cycle after the address
	always_ff @(posedge clk) begin
		rdData <= rowMem[rdAddr];
	end

endmodule

//--- pixelMerge.sv
module pixelMerge
	import renderPixelPkg::*;
(
	input  tileRowT    tileRow,
	input  logic       first,
	input  offsetT     offset,
	input  logic       flip,
	input  logic       blank,
	input  paletteT    palette,
	input  layerDepthT depth,
	input  carryT      carryIn,
	input  pixelWordT  curData,
	input  slotMaskT   curMask,
	input  depthWordT  curDepth,
	output pixelWordT  newData,
	output slotMaskT   newMask,
	output depthWordT  newDepth,
	output carryT      carryOut
);

	logic [3:0] rowPix [8];
	logic [3:0] stream [11];
	logic [3:0] slotColour [4];
	logic [3:0] windowBase;
	slotMaskT writeSlot;

	//////////////////////////////////////////////////////////////////////
	// Pixel stream
	//////////////////////////////////////////////////////////////////////

	// Row pixels in screen order, zero for the flush step
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			if (blank) begin
				rowPix[i] = 4'h0;
			end else if (flip) begin
				rowPix[i] = tileRow[4*(7-i) +: 4];
			end else begin
				rowPix[i] = tileRow[4*i +: 4];
			end
		end
	end

	// Carried F, G, H first, then the eight row pixels
	always_comb begin
		stream[0] = carryIn[3:0];
		stream[1] = carryIn[7:4];
		stream[2] = carryIn[11:8];
		for (int i = 0; i < 8; i++) begin
			stream[3+i] = rowPix[i];
		end
	end

	// Window start is 3 - offset, four further on for the high half
	assign windowBase = 4'd3 + {1'b0, first, 2'b00} - {2'b00, offset};

	always_comb begin
		for (int s = 0; s < 4; s++) begin
			slotColour[s] = stream[windowBase + 4'(s)];
		end
	end

	// Last three stream pixels go to the next tile
	assign carryOut = {rowPix[7], rowPix[6], rowPix[5]};

	//////////////////////////////////////////////////////////////////////
	// Depth merge
	//////////////////////////////////////////////////////////////////////

	// Colour 0 is transparent, an equal depth keeps the old pixel
	always_comb begin
		for (int s = 0; s < 4; s++) begin
			writeSlot[s] = (slotColour[s] != 4'h0) &&
				(!curMask[s] || (depth > curDepth[2*s +: 2]));
			newMask[s] = curMask[s] | writeSlot[s];
			newDepth[2*s +: 2] = writeSlot[s] ? depth : curDepth[2*s +: 2];
			newData[8*s +: 8] = writeSlot[s] ? {palette, slotColour[s]} : curData[8*s +: 8];
		end
	end

endmodule

//--- renderCtlPkg.sv
package renderCtlPkg;

	// Span sequencer, one pass per tile is fetch, low half, high half
	typedef enum logic [2:0] {
		seqIdle,
		seqFetch,
		seqLowHalf,
		seqHighHalf,
		seqFlush,
		seqScan
	} seqStateT;

	// Line buffer scan-out
	typedef enum logic {scanIdle, scanStream} scanStateT;

endpackage

//--- renderPixelPkg.sv
`include "tileLineRenderer_config.svh"

package renderPixelPkg;

	// Eight colour nibbles, pixel A lowest
	typedef logic [31:0] tileRowT;
	// Trailing pixels F, G, H of the previous tile, H on top
	typedef logic [11:0] carryT;

	// Four pixels of {palette, colour}, slot W lowest
	typedef logic [31:0] pixelWordT;
	typedef logic [7:0] depthWordT;
	typedef logic [3:0] slotMaskT;

	typedef logic [3:0] paletteT;
	typedef logic [1:0] layerDepthT;
	typedef logic [1:0] offsetT;

	// Addresses
	typedef logic [$clog2(`LINE_WORDS)-1:0] wordAddrT;
	typedef logic [$clog2(`TILE_COUNT)-1:0] tileIdT;
	typedef logic [$clog2(`TILE_ROWS)-1:0] tileRowIdT;

endpackage

//--- tileLineRenderer_config.svh
`ifndef TILE_LINE_RENDERER_CONFIG_SVH
`define TILE_LINE_RENDERER_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Line buffer geometry
//////////////////////////////////////////////////////////////////////

// Buffer words per scanline, four pixels each
`define LINE_WORDS 64

//////////////////////////////////////////////////////////////////////
// Tile store geometry
//////////////////////////////////////////////////////////////////////

// Tiles held in the store
`define TILE_COUNT 64

// Rows per tile, one 32-bit row of eight pixels each
`define TILE_ROWS 8

`endif
